// ==== rtl/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

	parameter int DATA_W = 32;
	parameter int TAG_W  = 4;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [TAG_W-1:0]  tag_t;

	// Zero tag marks an operand whose value is already held
	parameter tag_t TAG_NONE = '0;

	typedef enum logic [1:0] {
		OP_ADD   = 2'd0,
		OP_SUB   = 2'd1,
		OP_MUL   = 2'd2,
		OP_MULHU = 2'd3
	} op_t;

	typedef enum logic {
		ADD_PLUS  = 1'b0,
		ADD_MINUS = 1'b1
	} add_op_t;

	typedef enum logic {
		MUL_LO = 1'b0, // Low 32 bits of product
		MUL_HI = 1'b1  // High 32 bits, unsigned
	} mul_op_t;

	function automatic logic is_mul_op(op_t op);
		return (op == OP_MUL) || (op == OP_MULHU);
	endfunction

	// Station tag from class base and entry index
	function automatic tag_t make_tag(int base, int idx);
		return tag_t'(base + idx);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/rs_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue import rs_pkg::*; #(
	parameter int N_ADD = 3,
	parameter int N_MUL = 2
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              issue_valid,
	input  wire op_t         issue_op,
	input  wire data_t       issue_vj,
	input  wire data_t       issue_vk,
	input  wire tag_t        issue_qj,
	input  wire tag_t        issue_qk,
	input  wire [N_ADD-1:0]  add_free,
	input  wire [N_MUL-1:0]  mul_free,
	input  wire              cdb_valid,
	input  wire tag_t        cdb_tag,
	input  wire data_t       cdb_value,
	output logic             issue_ready,
	output tag_t             issue_tag,
	output logic [N_ADD-1:0] add_alloc,
	output logic [N_MUL-1:0] mul_alloc,
	output add_op_t          add_payload,
	output mul_op_t          mul_payload,
	output data_t            alloc_vj,
	output data_t            alloc_vk,
	output tag_t             alloc_qj,
	output tag_t             alloc_qk
);

	int   add_idx;
	int   mul_idx;
	logic mul_class;
	logic fire;
	logic qj_hit;
	logic qk_hit;

	// Lowest free station per class
	always_comb begin
		add_idx = 0;
		for (int i = N_ADD - 1; i >= 0; i--) begin
			if (add_free[i]) begin
				add_idx = i;
			end
		end
	end

	always_comb begin
		mul_idx = 0;
		for (int i = N_MUL - 1; i >= 0; i--) begin
			if (mul_free[i]) begin
				mul_idx = i;
			end
		end
	end

	assign mul_class   = is_mul_op(issue_op);
	assign issue_ready = mul_class ? (|mul_free) : (|add_free);
	assign issue_tag   = mul_class ? make_tag(N_ADD + 1, mul_idx) : make_tag(1, add_idx);
	assign fire        = issue_valid && issue_ready;

	assign add_alloc = (fire && !mul_class) ? (N_ADD'(1) << add_idx) : '0;
	assign mul_alloc = (fire && mul_class) ? (N_MUL'(1) << mul_idx) : '0;

	assign add_payload = (issue_op == OP_SUB) ? ADD_MINUS : ADD_PLUS;
	assign mul_payload = (issue_op == OP_MULHU) ? MUL_HI : MUL_LO;

	// Producer broadcasting in the issue cycle itself
	assign qj_hit = cdb_valid && (issue_qj != TAG_NONE) && (issue_qj == cdb_tag);
	assign qk_hit = cdb_valid && (issue_qk != TAG_NONE) && (issue_qk == cdb_tag);

	assign alloc_vj = qj_hit ? cdb_value : issue_vj;
	assign alloc_vk = qk_hit ? cdb_value : issue_vk;
	assign alloc_qj = qj_hit ? TAG_NONE : issue_qj;
	assign alloc_qk = qk_hit ? TAG_NONE : issue_qk;

	// Zero or the lowest set bit of the free vector
	a_alloc_lowest: assert property (@(posedge clk) disable iff (!rst_n)
		(add_alloc == '0 || add_alloc == (add_free & -add_free)) &&
		(mul_alloc == '0 || mul_alloc == (mul_free & -mul_free)));

endmodule

`default_nettype wire

// ==== rtl/rs_station_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_station_bank import rs_pkg::*; #(
	parameter int  N_ENTRY   = 3,
	parameter int  BASE_TAG  = 1,
	parameter type payload_t = add_op_t
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire [N_ENTRY-1:0]  alloc,
	input  wire payload_t      alloc_payload,
	input  wire data_t         alloc_vj,
	input  wire data_t         alloc_vk,
	input  wire tag_t          alloc_qj,
	input  wire tag_t          alloc_qk,
	input  wire [N_ENTRY-1:0]  grant,
	input  wire                cdb_valid,
	input  wire tag_t          cdb_tag,
	input  wire data_t         cdb_value,
	output logic [N_ENTRY-1:0] free,
	output logic [N_ENTRY-1:0] ready,
	output payload_t           entry_payload [N_ENTRY],
	output data_t              entry_vj [N_ENTRY],
	output data_t              entry_vk [N_ENTRY]
);

	logic [N_ENTRY-1:0] busy;  // Waiting or executing
	logic [N_ENTRY-1:0] exec;  // Sent to the unit, result pending
	tag_t               qj [N_ENTRY];
	tag_t               qk [N_ENTRY];
	logic [N_ENTRY-1:0] done;
	logic [N_ENTRY-1:0] hit_j;
	logic [N_ENTRY-1:0] hit_k;

	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			done[i]  = exec[i] && cdb_valid && (cdb_tag == make_tag(BASE_TAG, i));
			hit_j[i] = busy[i] && !exec[i] && cdb_valid &&
				(qj[i] != TAG_NONE) && (qj[i] == cdb_tag);
			hit_k[i] = busy[i] && !exec[i] && cdb_valid &&
				(qk[i] != TAG_NONE) && (qk[i] == cdb_tag);
			ready[i] = busy[i] && !exec[i] && (qj[i] == TAG_NONE) && (qk[i] == TAG_NONE);
		end
	end

	assign free = ~busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= '0;
			exec <= '0;
			for (int i = 0; i < N_ENTRY; i++) begin
				qj[i] <= TAG_NONE;
				qk[i] <= TAG_NONE;
			end
		end else begin
			for (int i = 0; i < N_ENTRY; i++) begin
				if (alloc[i]) begin
					busy[i] <= 1'b1;
					exec[i] <= 1'b0;
					qj[i]   <= alloc_qj;
					qk[i]   <= alloc_qk;
				end else if (done[i]) begin
					busy[i] <= 1'b0; // Own tag on CDB, station reusable
					exec[i] <= 1'b0;
				end else begin
					if (grant[i]) begin
						exec[i] <= 1'b1;
					end
					if (hit_j[i]) begin
						qj[i] <= TAG_NONE;
					end
					if (hit_k[i]) begin
						qk[i] <= TAG_NONE;
					end
				end
			end
		end
	end

	// Operand values and payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < N_ENTRY; i++) begin
			if (alloc[i]) begin
				entry_payload[i] <= alloc_payload;
				entry_vj[i]      <= alloc_vj;
				entry_vk[i]      <= alloc_vk;
			end else begin
				if (hit_j[i]) begin
					entry_vj[i] <= cdb_value;
				end
				if (hit_k[i]) begin
					entry_vk[i] <= cdb_value;
				end
			end
		end
	end

	a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
		(alloc & ~free) == '0);

	a_grant_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(grant & ~ready) == '0);

endmodule

`default_nettype wire

// ==== rtl/rs_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_dispatch import rs_pkg::*; #(
	parameter int  N_ENTRY   = 3,
	parameter int  BASE_TAG  = 1,
	parameter type payload_t = add_op_t
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire [N_ENTRY-1:0]  ready,
	input  wire payload_t      entry_payload [N_ENTRY],
	input  wire data_t         entry_vj [N_ENTRY],
	input  wire data_t         entry_vk [N_ENTRY],
	input  wire                unit_ready,
	output logic [N_ENTRY-1:0] grant,
	output logic               unit_valid,
	output payload_t           unit_op,
	output data_t              unit_vj,
	output data_t              unit_vk,
	output tag_t               unit_tag
);

	localparam int IDX_W = (N_ENTRY > 1) ? $clog2(N_ENTRY) : 1;

	logic             locked;    // Unit stalled on a presented entry
	logic [IDX_W-1:0] lock_idx;
	logic [IDX_W-1:0] pick_idx;
	logic [IDX_W-1:0] sel_idx;

	always_comb begin
		pick_idx = '0;
		for (int i = N_ENTRY - 1; i >= 0; i--) begin
			if (ready[i]) begin
				pick_idx = IDX_W'(i);
			end
		end
	end

	assign sel_idx    = locked ? lock_idx : pick_idx;
	assign unit_valid = |ready;  // Locked entry stays ready until granted

	assign unit_op  = entry_payload[sel_idx];
	assign unit_vj  = entry_vj[sel_idx];
	assign unit_vk  = entry_vk[sel_idx];
	assign unit_tag = make_tag(BASE_TAG, int'(sel_idx));

	assign grant = (unit_valid && unit_ready) ? (N_ENTRY'(1) << sel_idx) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			locked   <= 1'b0;
			lock_idx <= '0;
		end else if (unit_valid && !unit_ready) begin
			locked   <= 1'b1;
			lock_idx <= sel_idx;
		end else if (unit_valid && unit_ready) begin
			locked <= 1'b0;
		end
	end

	a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		unit_valid && !unit_ready |=> unit_valid && $stable(unit_tag) &&
			$stable(unit_op) && $stable(unit_vj) && $stable(unit_vk));

endmodule

`default_nettype wire

// ==== rtl/rs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_top import rs_pkg::*; #(
	parameter int N_ADD = 3,
	parameter int N_MUL = 2
) (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        issue_valid,
	input  wire op_t   issue_op,
	input  wire data_t issue_vj,
	input  wire data_t issue_vk,
	input  wire tag_t  issue_qj,
	input  wire tag_t  issue_qk,
	output logic       issue_ready,
	output tag_t       issue_tag,
	input  wire        cdb_valid,
	input  wire tag_t  cdb_tag,
	input  wire data_t cdb_value,
	output logic       add_valid,
	input  wire        add_ready,
	output add_op_t    add_op,
	output data_t      add_vj,
	output data_t      add_vk,
	output tag_t       add_tag,
	output logic       mul_valid,
	input  wire        mul_ready,
	output mul_op_t    mul_op,
	output data_t      mul_vj,
	output data_t      mul_vk,
	output tag_t       mul_tag
);

	logic [N_ADD-1:0] add_free;
	logic [N_MUL-1:0] mul_free;
	logic [N_ADD-1:0] add_alloc;
	logic [N_MUL-1:0] mul_alloc;
	add_op_t          add_payload;
	mul_op_t          mul_payload;
	data_t            alloc_vj;
	data_t            alloc_vk;
	tag_t             alloc_qj;
	tag_t             alloc_qk;

	logic [N_ADD-1:0] add_entry_ready;
	logic [N_MUL-1:0] mul_entry_ready;
	logic [N_ADD-1:0] add_grant;
	logic [N_MUL-1:0] mul_grant;
	add_op_t          add_entry_op [N_ADD];
	data_t            add_entry_vj [N_ADD];
	data_t            add_entry_vk [N_ADD];
	mul_op_t          mul_entry_op [N_MUL];
	data_t            mul_entry_vj [N_MUL];
	data_t            mul_entry_vk [N_MUL];

	rs_issue #(.N_ADD(N_ADD), .N_MUL(N_MUL)) u_issue (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_vj(issue_vj), .issue_vk(issue_vk),
		.issue_qj(issue_qj), .issue_qk(issue_qk),
		.add_free(add_free), .mul_free(mul_free),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.issue_ready(issue_ready), .issue_tag(issue_tag),
		.add_alloc(add_alloc), .mul_alloc(mul_alloc),
		.add_payload(add_payload), .mul_payload(mul_payload),
		.alloc_vj(alloc_vj), .alloc_vk(alloc_vk),
		.alloc_qj(alloc_qj), .alloc_qk(alloc_qk)
	);

	rs_station_bank #(.N_ENTRY(N_ADD), .BASE_TAG(1), .payload_t(add_op_t)) u_add_bank (
		.clk(clk), .rst_n(rst_n),
		.alloc(add_alloc), .alloc_payload(add_payload),
		.alloc_vj(alloc_vj), .alloc_vk(alloc_vk),
		.alloc_qj(alloc_qj), .alloc_qk(alloc_qk),
		.grant(add_grant),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.free(add_free), .ready(add_entry_ready),
		.entry_payload(add_entry_op), .entry_vj(add_entry_vj), .entry_vk(add_entry_vk)
	);

	// Multiplier tags follow the adder range
	rs_station_bank #(.N_ENTRY(N_MUL), .BASE_TAG(N_ADD + 1), .payload_t(mul_op_t)) u_mul_bank (
		.clk(clk), .rst_n(rst_n),
		.alloc(mul_alloc), .alloc_payload(mul_payload),
		.alloc_vj(alloc_vj), .alloc_vk(alloc_vk),
		.alloc_qj(alloc_qj), .alloc_qk(alloc_qk),
		.grant(mul_grant),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.free(mul_free), .ready(mul_entry_ready),
		.entry_payload(mul_entry_op), .entry_vj(mul_entry_vj), .entry_vk(mul_entry_vk)
	);

	rs_dispatch #(.N_ENTRY(N_ADD), .BASE_TAG(1), .payload_t(add_op_t)) u_add_disp (
		.clk(clk), .rst_n(rst_n),
		.ready(add_entry_ready), .entry_payload(add_entry_op),
		.entry_vj(add_entry_vj), .entry_vk(add_entry_vk),
		.unit_ready(add_ready), .grant(add_grant),
		.unit_valid(add_valid), .unit_op(add_op),
		.unit_vj(add_vj), .unit_vk(add_vk), .unit_tag(add_tag)
	);

	rs_dispatch #(.N_ENTRY(N_MUL), .BASE_TAG(N_ADD + 1), .payload_t(mul_op_t)) u_mul_disp (
		.clk(clk), .rst_n(rst_n),
		.ready(mul_entry_ready), .entry_payload(mul_entry_op),
		.entry_vj(mul_entry_vj), .entry_vk(mul_entry_vk),
		.unit_ready(mul_ready), .grant(mul_grant),
		.unit_valid(mul_valid), .unit_op(mul_op),
		.unit_vj(mul_vj), .unit_vk(mul_vk), .unit_tag(mul_tag)
	);

endmodule

`default_nettype wire

// ==== sim/rs_tb_model.svh ====
`ifndef RS_TB_MODEL_SVH
`define RS_TB_MODEL_SVH

logic [31:0] lfsr;
data_t       regs [8];     // Values seen through broadcasts
tag_t        rtag [8];     // Pending producer per register
data_t       golden [8];   // In-order architectural result
logic        st_busy [16];
logic        st_exec [16];
op_t         st_op [16];
data_t       exp_vj [16];
data_t       exp_vk [16];
tag_t        src_j [16];
tag_t        src_k [16];
data_t       result [16];

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

function automatic data_t exec_result(op_t op, data_t a, data_t b);
	logic [63:0] p;
	p = {32'b0, a} * {32'b0, b};
	case (op)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_MUL:  return p[31:0];
		default: return p[63:32];
	endcase
endfunction

function automatic int tag_lo(logic mul);
	return mul ? N_ADD + 1 : 1;
endfunction

function automatic int tag_hi(logic mul);
	return mul ? N_ADD + N_MUL : N_ADD;
endfunction

function automatic logic class_free(logic mul);
	for (int t = tag_lo(mul); t <= tag_hi(mul); t++) begin
		if (!st_busy[t]) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

function automatic logic any_busy();
	for (int t = 1; t <= N_ADD + N_MUL; t++) begin
		if (st_busy[t]) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

task automatic model_issue(tag_t t, op_t op, data_t vj, data_t vk, tag_t qj, tag_t qk,
		logic [2:0] rd, logic [2:0] rs1, logic [2:0] rs2);
	st_busy[t] = 1'b1;
	st_exec[t] = 1'b0;
	st_op[t]   = op;
	exp_vj[t]  = vj;
	exp_vk[t]  = vk;
	src_j[t]   = qj;
	src_k[t]   = qk;
	golden[rd] = exec_result(op, golden[rs1], golden[rs2]);
	rtag[rd]   = t;  // Rename after the sources were read
endtask

task automatic model_broadcast(tag_t t, data_t v);
	for (int s = 1; s <= N_ADD + N_MUL; s++) begin
		if (st_busy[s] && !st_exec[s] && src_j[s] == t) begin
			exp_vj[s] = v;
			src_j[s]  = TAG_NONE;
		end
		if (st_busy[s] && !st_exec[s] && src_k[s] == t) begin
			exp_vk[s] = v;
			src_k[s]  = TAG_NONE;
		end
	end
	for (int r = 0; r < 8; r++) begin
		if (rtag[r] == t) begin
			regs[r] = v;
			rtag[r] = TAG_NONE;
		end
	end
	st_busy[t] = 1'b0;
	st_exec[t] = 1'b0;
endtask

`endif

// ==== sim/rs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_tb import rs_pkg::*; ();

	localparam int N_ADD      = 3;
	localparam int N_MUL      = 2;
	localparam int N_INSTR    = 300;
	localparam int MAX_CYCLES = 20000;

	logic    clk;
	logic    rst_n;
	logic    issue_valid;
	op_t     issue_op;
	data_t   issue_vj;
	data_t   issue_vk;
	tag_t    issue_qj;
	tag_t    issue_qk;
	logic    issue_ready;
	tag_t    issue_tag;
	logic    cdb_valid;
	tag_t    cdb_tag;
	data_t   cdb_value;
	logic    add_valid;
	logic    add_ready;
	add_op_t add_op;
	data_t   add_vj;
	data_t   add_vk;
	tag_t    add_tag;
	logic    mul_valid;
	logic    mul_ready;
	mul_op_t mul_op;
	data_t   mul_vj;
	data_t   mul_vk;
	tag_t    mul_tag;

	`include "rs_tb_model.svh"

	int         value_errors;
	int         other_errors;
	int         issued;
	int         cycles;
	int         idx;
	logic       timed_out;
	logic       p_have;     // Next instruction generated, not yet issued
	op_t        p_op;
	logic [2:0] p_rd;
	logic [2:0] p_rs1;
	logic [2:0] p_rs2;
	tag_t       exec_q [$]; // Dispatched tags awaiting broadcast
	tag_t       t;
	logic       add_stall;
	logic       mul_stall;
	tag_t       add_h_tag;
	add_op_t    add_h_op;
	data_t      add_h_vj;
	data_t      add_h_vk;
	tag_t       mul_h_tag;
	mul_op_t    mul_h_op;
	data_t      mul_h_vj;
	data_t      mul_h_vk;

	rs_top #(.N_ADD(N_ADD), .N_MUL(N_MUL)) u_rs_top (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_vj(issue_vj), .issue_vk(issue_vk),
		.issue_qj(issue_qj), .issue_qk(issue_qk),
		.issue_ready(issue_ready), .issue_tag(issue_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.add_valid(add_valid), .add_ready(add_ready), .add_op(add_op),
		.add_vj(add_vj), .add_vk(add_vk), .add_tag(add_tag),
		.mul_valid(mul_valid), .mul_ready(mul_ready), .mul_op(mul_op),
		.mul_vj(mul_vj), .mul_vk(mul_vk), .mul_tag(mul_tag)
	);

	always #4 clk = ~clk;

	task automatic check_data(string name, data_t exp, data_t act);
		if (exp !== act) begin
			value_errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_tag(string name, tag_t exp, tag_t act);
		if (exp !== act) begin
			value_errors++;
			$display("[ERROR] %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_add_op(string name, add_op_t exp, add_op_t act);
		if (exp !== act) begin
			value_errors++;
			$display("[ERROR] %s expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_mul_op(string name, mul_op_t exp, mul_op_t act);
		if (exp !== act) begin
			value_errors++;
			$display("[ERROR] %s expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (exp !== act) begin
			value_errors++;
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic report_fault(string msg);
		other_errors++;
		$display("Failure at %0t: %s", $time, msg);
	endtask

	// Accept one dispatch and compute the unit's result from model operands
	task automatic take_dispatch(logic mul, tag_t tg, data_t vj, data_t vk);
		int ti;
		ti = int'(tg);
		if (ti < tag_lo(mul) || ti > tag_hi(mul) || !st_busy[ti] || st_exec[ti]) begin
			report_fault($sformatf("tag %0d dispatched without a waiting station", ti));
			return;
		end
		if (src_j[ti] != TAG_NONE || src_k[ti] != TAG_NONE) begin
			report_fault($sformatf("tag %0d dispatched before its operands arrived", ti));
		end
		check_data("dispatch vj", exp_vj[ti], vj);
		check_data("dispatch vk", exp_vk[ti], vk);
		result[ti]  = exec_result(st_op[ti], exp_vj[ti], exp_vk[ti]);
		st_exec[ti] = 1'b1;
		exec_q.push_back(tg);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_vj = '0;
		issue_vk = '0;
		issue_qj = TAG_NONE;
		issue_qk = TAG_NONE;
		cdb_valid = 1'b0;
		cdb_tag = TAG_NONE;
		cdb_value = '0;
		add_ready = 1'b0;
		mul_ready = 1'b0;
		lfsr = 32'h45bd_a7d1;
		value_errors = 0;
		other_errors = 0;
		issued = 0;
		timed_out = 1'b0;
		p_have = 1'b0;
		add_stall = 1'b0;
		mul_stall = 1'b0;
		for (int r = 0; r < 8; r++) begin
			regs[r]   = 32'h9e37_79b9 * (r + 1);
			golden[r] = regs[r];
			rtag[r]   = TAG_NONE;
		end
		for (int s = 0; s < 16; s++) begin
			st_busy[s] = 1'b0;
			st_exec[s] = 1'b0;
		end

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_flag("reset add_valid", 1'b0, add_valid);
		check_flag("reset mul_valid", 1'b0, mul_valid);
		check_flag("reset issue_ready add", 1'b1, issue_ready);
		issue_op <= OP_MUL;
		@(posedge clk);
		check_flag("reset issue_ready mul", 1'b1, issue_ready);

		cycles = 0;
		while (!timed_out && (issued < N_INSTR || any_busy())) begin
			@(posedge clk);
			cycles++;
			check_flag("issue_ready", class_free(is_mul_op(issue_op)), issue_ready);

			// Held dispatch must not change until the handshake
			if (add_stall) begin
				check_flag("add hold valid", 1'b1, add_valid);
				check_tag("add hold tag", add_h_tag, add_tag);
				check_add_op("add hold op", add_h_op, add_op);
				check_data("add hold vj", add_h_vj, add_vj);
				check_data("add hold vk", add_h_vk, add_vk);
			end
			if (mul_stall) begin
				check_flag("mul hold valid", 1'b1, mul_valid);
				check_tag("mul hold tag", mul_h_tag, mul_tag);
				check_mul_op("mul hold op", mul_h_op, mul_op);
				check_data("mul hold vj", mul_h_vj, mul_vj);
				check_data("mul hold vk", mul_h_vk, mul_vk);
			end
			add_stall = add_valid && !add_ready;
			mul_stall = mul_valid && !mul_ready;
			add_h_tag = add_tag;
			add_h_op  = add_op;
			add_h_vj  = add_vj;
			add_h_vk  = add_vk;
			mul_h_tag = mul_tag;
			mul_h_op  = mul_op;
			mul_h_vj  = mul_vj;
			mul_h_vk  = mul_vk;

			if (add_valid && add_ready) begin
				check_add_op("add op", (st_op[add_tag] == OP_SUB) ? ADD_MINUS : ADD_PLUS, add_op);
				take_dispatch(1'b0, add_tag, add_vj, add_vk);
			end
			if (mul_valid && mul_ready) begin
				check_mul_op("mul op", (st_op[mul_tag] == OP_MULHU) ? MUL_HI : MUL_LO, mul_op);
				take_dispatch(1'b1, mul_tag, mul_vj, mul_vk);
			end

			if (issue_valid && issue_ready) begin
				t = issue_tag;
				if (int'(t) < tag_lo(is_mul_op(issue_op)) || int'(t) > tag_hi(is_mul_op(issue_op))
						|| st_busy[t]) begin
					report_fault($sformatf("issue got tag %0d, not a free station", t));
				end
				model_issue(t, issue_op, issue_vj, issue_vk, issue_qj, issue_qk,
					p_rd, p_rs1, p_rs2);
				issued++;
				p_have = 1'b0;
			end
			// Same-cycle broadcast is applied after the issue it may feed
			if (cdb_valid) begin
				model_broadcast(cdb_tag, cdb_value);
			end

			if (!p_have && issued < N_INSTR) begin
				p_op   = op_t'(2'(rand_bits(2)));
				p_rd   = 3'(rand_bits(3));
				p_rs1  = 3'(rand_bits(3));
				p_rs2  = 3'(rand_bits(3));
				p_have = 1'b1;
			end
			if (p_have) begin
				issue_op    <= p_op;
				issue_qj    <= rtag[p_rs1];
				issue_qk    <= rtag[p_rs2];
				issue_vj    <= (rtag[p_rs1] == TAG_NONE) ? regs[p_rs1] : '0;
				issue_vk    <= (rtag[p_rs2] == TAG_NONE) ? regs[p_rs2] : '0;
				issue_valid <= class_free(is_mul_op(p_op)) && (rand_bits(2) != 0);
			end else begin
				issue_valid <= 1'b0;
			end

			add_ready <= (rand_bits(2) != 0);
			mul_ready <= (rand_bits(2) != 0);

			if (exec_q.size() > 0 && rand_bits(2) != 0) begin
				idx = int'(rand_bits(3)) % exec_q.size();
				t   = exec_q[idx];
				exec_q.delete(idx);
				cdb_valid <= 1'b1;
				cdb_tag   <= t;
				cdb_value <= result[t];
			end else begin
				cdb_valid <= 1'b0;
			end

			if (cycles >= MAX_CYCLES) begin
				timed_out = 1'b1;
				report_fault("timeout, instruction stream did not drain");
			end
		end

		for (int r = 0; r < 8; r++) begin
			check_data("final register", golden[r], regs[r]);
		end

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rs_top.f ====
+incdir+sim
rtl/rs_pkg.sv
rtl/rs_issue.sv
rtl/rs_station_bank.sv
rtl/rs_dispatch.sv
rtl/rs_top.sv
sim/rs_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := rs_tb
FILELIST  := rs_top.f
FLAGS     := --binary --timing --assert
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
